// ==== hdl/axi_addr_pkg.sv ====
// AXI address channel widths and beat layout; widths are fixed here, so the user field is one bit
`default_nettype none

package axi_addr_pkg;

    localparam int ADDR_W = 32;                 // virtual and physical address width
    localparam int ID_W   = 8;                  // transaction id width
    localparam int USER_W = 1;                  // user sideband width

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // one address beat as seen on AR or AW, same layout both ways
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;                // replaced by the physical address on issue
        logic [7:0]        len;                 // beats in the burst minus one
        logic [2:0]        size;                // bytes per beat as a power of two
        axi_burst_e        burst;
        logic [2:0]        prot;
        logic [3:0]        cache;
        logic [USER_W-1:0] user;
        logic              lock;
    } addr_beat_t;

endpackage

`default_nettype wire

// ==== hdl/rab_xlate_pkg.sv ====
// translation unit request/response layout and channel states; response bit 32 set means drop
`default_nettype none

package rab_xlate_pkg;

    // request to the translation unit, the pad keeps it byte aligned at 56 bits
    typedef struct packed {
        logic [4:0]                      pad;   // always zero
        logic [2:0]                      size;
        logic [7:0]                      len;
        logic [axi_addr_pkg::ID_W-1:0]   id;    // the translation unit uses this as a process id
        logic [axi_addr_pkg::ADDR_W-1:0] vaddr;
    } xlate_req_t;

    // response from the translation unit, 40 bits
    typedef struct packed {
        logic [6:0]                      pad;
        logic                            drop;  // 1 discards the beat, 0 means translation done
        logic [axi_addr_pkg::ADDR_W-1:0] paddr;
    } xlate_resp_t;

    // per channel sequencing of one translation
    typedef enum logic [1:0] {
        IDLE      = 2'd0,                       // waiting for a buffered beat
        REQ       = 2'd1,                       // request valid, waiting for tready
        WAIT_RESP = 2'd2,                       // request taken, waiting for the answer
        ISSUE     = 2'd3                        // translated beat offered downstream
    } chan_state_e;

endpackage

`default_nettype wire

// ==== hdl/addr_buffer.sv ====
// address beat FIFO; BUF_DEPTH must be a power of two and at least 2, head shows without a pop
`timescale 1ns/1ns
`default_nettype none

module addr_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                     s_axi_clk,
    input  logic                     s_aresetn,
    input  axi_addr_pkg::addr_beat_t wr_beat,
    input  logic                     wr_en,
    output logic                     full,
    output axi_addr_pkg::addr_beat_t rd_beat,
    input  logic                     rd_en,
    output logic                     empty
);

    localparam int PTR_W = $clog2(BUF_DEPTH);

    axi_addr_pkg::addr_beat_t mem [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                    // one extra bit so full and empty differ
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == (PTR_W+1)'(BUF_DEPTH));
    assign empty = (count == '0);

    assign do_wr = wr_en && !full;              // writes into a full buffer are dropped
    assign do_rd = rd_en && !empty;             // reads from an empty buffer do nothing

    assign rd_beat = mem[rd_ptr];

    always_ff @(posedge s_axi_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge s_axi_clk) begin
        if (!s_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + PTR_W'(1);   // wraps on its own since depth is a power of two
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + (PTR_W+1)'(1);
                2'b01:   count <= count - (PTR_W+1)'(1);
                default: count <= count;        // both or neither leave occupancy as is
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/xlate_channel.sv ====
// one remapping channel; a single translation is in flight and dropped beats vanish silently
`timescale 1ns/1ns
`default_nettype none

module xlate_channel #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                      s_axi_clk,
    input  logic                      s_aresetn,

    // upstream master side
    input  axi_addr_pkg::addr_beat_t  s_beat,
    input  logic                      s_valid,
    output logic                      s_ready,

    // downstream slave side
    output axi_addr_pkg::addr_beat_t  m_beat,
    output logic                      m_valid,
    input  logic                      m_ready,

    // translation unit
    output rab_xlate_pkg::xlate_req_t req,
    output logic                      req_valid,
    input  logic                      req_ready,
    input  rab_xlate_pkg::xlate_resp_t resp,
    input  logic                      resp_valid
);

    rab_xlate_pkg::chan_state_e state;

    axi_addr_pkg::addr_beat_t head;             // oldest buffered beat
    axi_addr_pkg::addr_beat_t issue_q;          // translated beat waiting for the slave
    logic                     buf_full;
    logic                     buf_empty;
    logic                     pop;

    // the head is only released when the answer for it arrives
    assign pop = (state == rab_xlate_pkg::WAIT_RESP) && resp_valid;

    addr_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_addr_buffer (
        .s_axi_clk (s_axi_clk),
        .s_aresetn (s_aresetn),
        .wr_beat   (s_beat),
        .wr_en     (s_valid),
        .full      (buf_full),
        .rd_beat   (head),
        .rd_en     (pop),
        .empty     (buf_empty)
    );

    assign s_ready = !buf_full;

    // the head stays put until the pop, so the request can be built straight from it
    always_comb begin
        req.pad   = '0;
        req.size  = head.size;
        req.len   = head.len;
        req.id    = head.id;
        req.vaddr = head.addr;
    end

    assign req_valid = (state == rab_xlate_pkg::REQ);
    assign m_valid   = (state == rab_xlate_pkg::ISSUE);
    assign m_beat    = issue_q;

    always_ff @(posedge s_axi_clk) begin
        if (!s_aresetn) begin
            state <= rab_xlate_pkg::IDLE;
        end else begin
            case (state)
                rab_xlate_pkg::IDLE: begin
                    if (!buf_empty) begin
                        state <= rab_xlate_pkg::REQ;
                    end
                end
                rab_xlate_pkg::REQ: begin
                    if (req_ready) begin
                        state <= rab_xlate_pkg::WAIT_RESP;
                    end
                end
                rab_xlate_pkg::WAIT_RESP: begin
                    if (resp_valid) begin
                        // a drop goes straight back and never reaches the slave
                        state <= resp.drop ? rab_xlate_pkg::IDLE : rab_xlate_pkg::ISSUE;
                    end
                end
                rab_xlate_pkg::ISSUE: begin
                    if (m_ready) begin
                        state <= rab_xlate_pkg::IDLE;
                    end
                end
                default: state <= rab_xlate_pkg::IDLE;
            endcase
        end
    end

    // capture the beat with its physical address on a done answer
    always_ff @(posedge s_axi_clk) begin
        if (pop && !resp.drop) begin
            issue_q      <= head;
            issue_q.addr <= resp.paddr;         // everything else passes through untouched
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axi_rab_top.sv ====
// RAB top with AR and AW only; translation responses are always accepted, so no response tready
`timescale 1ns/1ns
`default_nettype none

module axi_rab_top #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                       s_axi_clk,
    input  logic                       s_aresetn,

    // read address channel from the master
    input  axi_addr_pkg::addr_beat_t   s_axi_ar,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,

    // write address channel from the master
    input  axi_addr_pkg::addr_beat_t   s_axi_aw,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,

    // read address channel to the slave
    output axi_addr_pkg::addr_beat_t   m_axi_ar,
    output logic                       m_axi_arvalid,
    input  logic                       m_axi_arready,

    // write address channel to the slave
    output axi_addr_pkg::addr_beat_t   m_axi_aw,
    output logic                       m_axi_awvalid,
    input  logic                       m_axi_awready,

    // requests to the translation unit
    output rab_xlate_pkg::xlate_req_t  to_mmu_rd_tdata,
    output logic                       to_mmu_rd_tvalid,
    input  logic                       to_mmu_rd_tready,
    output rab_xlate_pkg::xlate_req_t  to_mmu_wr_tdata,
    output logic                       to_mmu_wr_tvalid,
    input  logic                       to_mmu_wr_tready,

    // responses from the translation unit
    input  rab_xlate_pkg::xlate_resp_t from_mmu_rd_tdata,
    input  logic                       from_mmu_rd_tvalid,
    input  rab_xlate_pkg::xlate_resp_t from_mmu_wr_tdata,
    input  logic                       from_mmu_wr_tvalid
);

    // index 0 is the read channel, index 1 the write channel
    axi_addr_pkg::addr_beat_t   s_beat     [2];
    logic                       s_valid    [2];
    logic                       s_ready    [2];
    axi_addr_pkg::addr_beat_t   m_beat     [2];
    logic                       m_valid    [2];
    logic                       m_ready    [2];
    rab_xlate_pkg::xlate_req_t  req        [2];
    logic                       req_valid  [2];
    logic                       req_ready  [2];
    rab_xlate_pkg::xlate_resp_t resp       [2];
    logic                       resp_valid [2];

    assign s_beat[0]     = s_axi_ar;
    assign s_valid[0]    = s_axi_arvalid;
    assign m_ready[0]    = m_axi_arready;
    assign req_ready[0]  = to_mmu_rd_tready;
    assign resp[0]       = from_mmu_rd_tdata;
    assign resp_valid[0] = from_mmu_rd_tvalid;

    assign s_beat[1]     = s_axi_aw;
    assign s_valid[1]    = s_axi_awvalid;
    assign m_ready[1]    = m_axi_awready;
    assign req_ready[1]  = to_mmu_wr_tready;
    assign resp[1]       = from_mmu_wr_tdata;
    assign resp_valid[1] = from_mmu_wr_tvalid;

    assign s_axi_arready    = s_ready[0];
    assign m_axi_ar         = m_beat[0];
    assign m_axi_arvalid    = m_valid[0];
    assign to_mmu_rd_tdata  = req[0];
    assign to_mmu_rd_tvalid = req_valid[0];

    assign s_axi_awready    = s_ready[1];
    assign m_axi_aw         = m_beat[1];
    assign m_axi_awvalid    = m_valid[1];
    assign to_mmu_wr_tdata  = req[1];
    assign to_mmu_wr_tvalid = req_valid[1];

    // the two channels are fully independent copies
    for (genvar i = 0; i < 2; i++) begin : g_chan
        xlate_channel #(
            .BUF_DEPTH  (BUF_DEPTH)
        ) u_xlate_channel (
            .s_axi_clk  (s_axi_clk),
            .s_aresetn  (s_aresetn),
            .s_beat     (s_beat[i]),
            .s_valid    (s_valid[i]),
            .s_ready    (s_ready[i]),
            .m_beat     (m_beat[i]),
            .m_valid    (m_valid[i]),
            .m_ready    (m_ready[i]),
            .req        (req[i]),
            .req_valid  (req_valid[i]),
            .req_ready  (req_ready[i]),
            .resp       (resp[i]),
            .resp_valid (resp_valid[i])
        );
    end

endmodule

`default_nettype wire

// ==== testbench/tb_axi_rab_top.sv ====
// testbench for axi_rab_top with BUF_DEPTH 4; the fill check needs at least five read rows
`timescale 1ns/1ns
`default_nettype none

module tb_axi_rab_top;

    localparam int BUF_DEPTH = 4;
    localparam int NUM_ROWS  = 14;
    localparam int TIMEOUT   = 200;             // cycles allowed for any single wait

    typedef struct {
        int                                ch;  // 0 read, 1 write
        axi_addr_pkg::addr_beat_t          beat;
        logic                              drop;
        logic [axi_addr_pkg::ADDR_W-1:0]   paddr;
        int                                resp_dly;
        int                                stall;
        rab_xlate_pkg::xlate_req_t         exp_req;
        axi_addr_pkg::addr_beat_t          exp_beat;
    } row_t;

    logic                       s_axi_clk;
    logic                       s_aresetn;
    axi_addr_pkg::addr_beat_t   up_beat    [2];
    logic                       up_valid   [2];
    logic                       up_ready   [2];
    axi_addr_pkg::addr_beat_t   dn_beat    [2];
    logic                       dn_valid   [2];
    logic                       dn_ready   [2];
    rab_xlate_pkg::xlate_req_t  req_data   [2];
    logic                       req_valid  [2];
    logic                       req_ready  [2];
    rab_xlate_pkg::xlate_resp_t resp_data  [2];
    logic                       resp_valid [2];

    row_t   rows [NUM_ROWS];
    logic   fill_seen;                          // the fifth read beat found the buffer full
    logic   popped [2];                         // at least one response taken on the channel
    int     mismatches;
    int     timeouts;
    int     failures;
    integer seed;

    axi_rab_top #(
        .BUF_DEPTH          (BUF_DEPTH)
    ) u_axi_rab_top (
        .s_axi_clk          (s_axi_clk),
        .s_aresetn          (s_aresetn),
        .s_axi_ar           (up_beat[0]),
        .s_axi_arvalid      (up_valid[0]),
        .s_axi_arready      (up_ready[0]),
        .s_axi_aw           (up_beat[1]),
        .s_axi_awvalid      (up_valid[1]),
        .s_axi_awready      (up_ready[1]),
        .m_axi_ar           (dn_beat[0]),
        .m_axi_arvalid      (dn_valid[0]),
        .m_axi_arready      (dn_ready[0]),
        .m_axi_aw           (dn_beat[1]),
        .m_axi_awvalid      (dn_valid[1]),
        .m_axi_awready      (dn_ready[1]),
        .to_mmu_rd_tdata    (req_data[0]),
        .to_mmu_rd_tvalid   (req_valid[0]),
        .to_mmu_rd_tready   (req_ready[0]),
        .to_mmu_wr_tdata    (req_data[1]),
        .to_mmu_wr_tvalid   (req_valid[1]),
        .to_mmu_wr_tready   (req_ready[1]),
        .from_mmu_rd_tdata  (resp_data[0]),
        .from_mmu_rd_tvalid (resp_valid[0]),
        .from_mmu_wr_tdata  (resp_data[1]),
        .from_mmu_wr_tvalid (resp_valid[1])
    );

    always #20 s_axi_clk = ~s_axi_clk;

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_req(input string name, input rab_xlate_pkg::xlate_req_t got,
                               input rab_xlate_pkg::xlate_req_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_beat(input string name, input axi_addr_pkg::addr_beat_t got,
                                input axi_addr_pkg::addr_beat_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s never arrived", what);
        timeouts++;
    endtask

    // both channels quiet with empty buffers
    task automatic check_idle();
        compare_bit("m_axi_arvalid", dn_valid[0], 1'b0);
        compare_bit("m_axi_awvalid", dn_valid[1], 1'b0);
        compare_bit("to_mmu_rd_tvalid", req_valid[0], 1'b0);
        compare_bit("to_mmu_wr_tvalid", req_valid[1], 1'b0);
        compare_bit("s_axi_arready", up_ready[0], 1'b1);
        compare_bit("s_axi_awready", up_ready[1], 1'b1);
    endtask

    task automatic build_table();
        logic [31:0] r;
        seed = 32'h1716;
        rows[0].ch   = 0;                       // read, translated, slave stalls three cycles
        rows[0].beat = '{id: 8'h11, addr: 32'h0000_1000, len: 8'h03, size: 3'h2,
                         burst: axi_addr_pkg::INCR, prot: 3'h0, cache: 4'h3, user: 1'b0,
                         lock: 1'b0};
        rows[0].drop = 1'b0;
        rows[0].paddr = 32'h8000_1000;
        rows[0].resp_dly = 2;
        rows[0].stall = 3;
        rows[1].ch   = 1;                       // write that the translation unit drops
        rows[1].beat = '{id: 8'h22, addr: 32'h0000_2040, len: 8'h00, size: 3'h3,
                         burst: axi_addr_pkg::WRAP, prot: 3'h2, cache: 4'hf, user: 1'b1,
                         lock: 1'b1};
        rows[1].drop = 1'b1;
        rows[1].paddr = 32'hdead_0000;
        rows[1].resp_dly = 0;
        rows[1].stall = 0;
        for (int i = 2; i < NUM_ROWS; i++) begin
            rows[i].ch = (i % 3 == 1) ? 1 : 0;
            rows[i].beat.addr = $random(seed);
            rows[i].paddr = $random(seed);
            r = $random(seed);
            rows[i].beat.id    = r[7:0];
            rows[i].beat.len   = r[15:8];
            rows[i].beat.size  = r[18:16];
            rows[i].beat.burst = (r[20:19] == 2'b11) ? axi_addr_pkg::INCR
                                                     : axi_addr_pkg::axi_burst_e'(r[20:19]);
            rows[i].beat.prot  = r[23:21];
            rows[i].beat.cache = r[27:24];
            rows[i].beat.user  = r[28];
            rows[i].beat.lock  = r[29];
            r = $random(seed);
            rows[i].drop     = (r[1:0] == 2'b00);  // roughly one in four dropped
            rows[i].resp_dly = int'(r[3:2]);
            rows[i].stall    = int'(r[5:4]);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            rows[i].exp_req.pad   = 5'd0;
            rows[i].exp_req.size  = rows[i].beat.size;
            rows[i].exp_req.len   = rows[i].beat.len;
            rows[i].exp_req.id    = rows[i].beat.id;
            rows[i].exp_req.vaddr = rows[i].beat.addr;
            rows[i].exp_beat      = rows[i].beat;
            rows[i].exp_beat.addr = rows[i].paddr;
        end
    endtask

    // master side of one channel, pushing its rows in table order
    task automatic feed(input int ch);
        int    n;
        int    t;
        string name;
        n = 0;
        name = (ch == 0) ? "s_axi_arready" : "s_axi_awready";
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].ch == ch) begin
                @(posedge s_axi_clk);
                up_beat[ch]  <= rows[i].beat;
                up_valid[ch] <= 1'b1;
                @(negedge s_axi_clk);
                if (ch == 0 && n == BUF_DEPTH) begin
                    compare_bit(name, up_ready[ch], 1'b0);  // four beats behind a stalled request
                    fill_seen = 1'b1;
                end
                t = 0;
                while (!up_ready[ch] && t < TIMEOUT) begin
                    @(negedge s_axi_clk);
                    t++;
                end
                if (!up_ready[ch]) begin
                    report_timeout(name);
                end else if (ch == 0 && n == BUF_DEPTH && !popped[0]) begin
                    $display("error: %s rose before any entry was popped", name);
                    failures++;
                end
                @(posedge s_axi_clk);           // the beat transfers on this edge
                up_valid[ch] <= 1'b0;
                n++;
            end
        end
    endtask

    // translation unit and slave for one channel
    task automatic serve(input int ch);
        int    t;
        string req_name;
        string dn_name;
        string dn_vname;
        req_name = (ch == 0) ? "to_mmu_rd_tdata" : "to_mmu_wr_tdata";
        dn_name  = (ch == 0) ? "m_axi_ar" : "m_axi_aw";
        dn_vname = (ch == 0) ? "m_axi_arvalid" : "m_axi_awvalid";
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].ch != ch) begin
                continue;
            end
            t = 0;
            @(negedge s_axi_clk);
            while (!req_valid[ch] && t < TIMEOUT) begin
                compare_bit(dn_vname, dn_valid[ch], 1'b0);  // a dropped beat never shows up
                @(negedge s_axi_clk);
                t++;
            end
            if (!req_valid[ch]) begin
                report_timeout({req_name, " request"});
                continue;
            end
            compare_req(req_name, req_data[ch], rows[i].exp_req);
            t = 0;
            while (ch == 0 && !fill_seen && t < TIMEOUT) begin
                @(negedge s_axi_clk);
                compare_req(req_name, req_data[ch], rows[i].exp_req);  // held while tready is low
                t++;
            end
            if (ch == 0 && !fill_seen) begin
                report_timeout("a full read buffer");
            end
            @(posedge s_axi_clk);
            req_ready[ch] <= 1'b1;
            @(posedge s_axi_clk);               // request taken here
            req_ready[ch] <= 1'b0;
            repeat (rows[i].resp_dly) @(posedge s_axi_clk);
            resp_data[ch]  <= '{pad: 7'd0, drop: rows[i].drop, paddr: rows[i].paddr};
            resp_valid[ch] <= 1'b1;
            @(posedge s_axi_clk);
            resp_valid[ch] <= 1'b0;
            popped[ch] = 1'b1;
            if (rows[i].drop) begin
                continue;
            end
            t = 0;
            @(negedge s_axi_clk);
            while (!dn_valid[ch] && t < TIMEOUT) begin
                @(negedge s_axi_clk);
                t++;
            end
            if (!dn_valid[ch]) begin
                report_timeout(dn_vname);
                continue;
            end
            compare_beat(dn_name, dn_beat[ch], rows[i].exp_beat);
            for (int s = 0; s < rows[i].stall; s++) begin
                @(negedge s_axi_clk);
                compare_bit(dn_vname, dn_valid[ch], 1'b1);
                compare_beat(dn_name, dn_beat[ch], rows[i].exp_beat);
            end
            @(posedge s_axi_clk);
            dn_ready[ch] <= 1'b1;
            @(posedge s_axi_clk);               // the slave takes the beat here
            dn_ready[ch] <= 1'b0;
        end
    endtask

    initial begin
        s_axi_clk  = 1'b0;
        s_aresetn  <= 1'b0;
        fill_seen  = 1'b0;
        mismatches = 0;
        timeouts   = 0;
        failures   = 0;
        for (int c = 0; c < 2; c++) begin
            up_beat[c]    <= '0;
            up_valid[c]   <= 1'b0;
            dn_ready[c]   <= 1'b0;
            req_ready[c]  <= 1'b0;
            resp_data[c]  <= '0;
            resp_valid[c] <= 1'b0;
            popped[c]     = 1'b0;
        end
        build_table();
        repeat (3) @(posedge s_axi_clk);
        s_aresetn <= 1'b1;
        @(negedge s_axi_clk);
        check_idle();
        fork
            feed(0);
            feed(1);
            serve(0);
            serve(1);
        join
        @(negedge s_axi_clk);
        check_idle();
        $display("errors: %0d mismatches, %0d timeouts, %0d other failures",
                 mismatches, timeouts, failures);
        if (mismatches == 0 && timeouts == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/axi_addr_pkg.sv
hdl/rab_xlate_pkg.sv
hdl/addr_buffer.sv
hdl/xlate_channel.sv
hdl/axi_rab_top.sv
testbench/tb_axi_rab_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ns -j 0 \
		--top-module tb_axi_rab_top -f filelist.f -o sim_tb

run: compile
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; \
		echo "$$out" | grep -q '^PASS: all tests$$'

clean:
	rm -rf obj_dir
